/* bench/gpmc_async_tb.sv */
// Testbench for the GPMC bridge with stimulus table, host bus tasks, stream drivers and watchdog
`timescale 1ns/1ps
`include "gpmc_params.svh"

module gpmc_async_tb
   import gpmc_pkg::*;
();

   localparam int FIFO_DEPTH = 1 << `GPMC_FIFO_AW;
   // Stalled TX path holds the FIFO plus one line in the packer
   localparam int TX_CAP     = FIFO_DEPTH + 2;
   // RX path with no reads holds the FIFO plus one line in the splitter
   localparam int RX_CAP     = FIFO_DEPTH + 2;
   localparam int NUM_ROWS   = 10;

   typedef enum logic [1:0] {
      ROW_TX,
      ROW_TX_OVF,
      ROW_RX,
      ROW_RX_OVF
   } row_kind_t;

   typedef enum logic [1:0] {
      BP_NONE,
      BP_RAND,
      BP_HOLD
   } bp_mode_t;

   typedef struct packed {
      row_kind_t  kind;
      frame_len_t len;
      gpmc_word_t base;
      bp_mode_t   bp;
   } row_t;

   // Kind, frame length, data base, TX back-pressure
   row_t rows [NUM_ROWS] = '{
      '{ROW_TX,     16'd8,  16'h1000, BP_NONE},
      '{ROW_TX,     16'd5,  16'h2000, BP_NONE},
      '{ROW_TX,     16'd1,  16'h2100, BP_RAND},
      '{ROW_TX,     16'd40, 16'h3000, BP_HOLD},
      '{ROW_TX,     16'd17, 16'h3800, BP_RAND},
      '{ROW_TX_OVF, 16'd68, 16'h4000, BP_HOLD},
      '{ROW_RX,     16'd6,  16'h5000, BP_NONE},
      '{ROW_RX,     16'd9,  16'h6000, BP_NONE},
      '{ROW_RX_OVF, 16'd80, 16'h7000, BP_NONE},
      '{ROW_TX,     16'd3,  16'h8000, BP_NONE}
   };

   logic        fifo_clk = 1'b0;
   logic        rst_n;
   wire  gpmc_word_t em_d;
   logic        em_drive;
   gpmc_word_t  em_d_drv;
   logic        em_ncs4_n;
   logic        em_nwe;
   logic        em_noe;
   logic        rx_have_data;
   logic        tx_have_space;
   logic        bus_error;
   logic        bus_reset;
   fifo_line_t  tx_data;
   logic        tx_src_rdy;
   logic        tx_dst_rdy;
   fifo_line_t  rx_data;
   logic        rx_src_rdy;
   logic        rx_dst_rdy;
   frame_len_t  tx_frame_len;
   frame_len_t  rx_frame_len;

   logic        tx_hold;
   logic        rand_bp;
   int          rx_lines_sent;
   fifo_line_t  exp_lines [$];
   fifo_line_t  got_lines [$];

   assign em_d = em_drive ? em_d_drv : 'z;

   gpmc_async gpmc_async_i (
      .fifo_clk_i      (fifo_clk),
      .rst_n_i         (rst_n),
      .em_d_io         (em_d),
      .em_ncs4_n_i     (em_ncs4_n),
      .em_nwe_i        (em_nwe),
      .em_noe_i        (em_noe),
      .rx_have_data_o  (rx_have_data),
      .tx_have_space_o (tx_have_space),
      .bus_error_o     (bus_error),
      .bus_reset_i     (bus_reset),
      .tx_data_o       (tx_data),
      .tx_src_rdy_o    (tx_src_rdy),
      .tx_dst_rdy_i    (tx_dst_rdy),
      .rx_data_i       (rx_data),
      .rx_src_rdy_i    (rx_src_rdy),
      .rx_dst_rdy_o    (rx_dst_rdy),
      .tx_frame_len_i  (tx_frame_len),
      .rx_frame_len_o  (rx_frame_len)
   );

   initial begin
      forever #50 fifo_clk = ~fifo_clk;
   end

   // TX stream sink, ready pattern set per row
   initial begin
      void'($urandom(91));
      tx_dst_rdy = 1'b1;
      forever begin
         @(negedge fifo_clk);
         if (tx_hold)
            tx_dst_rdy = 1'b0;
         else if (rand_bp)
            tx_dst_rdy = $urandom % 2;
         else
            tx_dst_rdy = 1'b1;
      end
   end

   // Collect every TX line at its transfer edge
   always @(posedge fifo_clk) begin
      if (tx_src_rdy && tx_dst_rdy)
         got_lines.push_back(tx_data);
   end

   ////////////////////////////////////////////////////////////
   // Reporting and compare tasks
   ////////////////////////////////////////////////////////////

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_word(string name, gpmc_word_t got, gpmc_word_t exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_line(string name, fifo_line_t got, fifo_line_t exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_len(string name, frame_len_t got, frame_len_t exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////
   // Stream line model, host bus and stream drivers
   ////////////////////////////////////////////////////////////

   // Line carrying words i and i+1 of an n-word frame
   function automatic fifo_line_t make_line(int n, int i, gpmc_word_t base);
      gpmc_word_t w0;
      gpmc_word_t w1;
      logic       sof;
      logic       eof;
      w0  = gpmc_word_t'(base + i);
      w1  = gpmc_word_t'(base + i + 1);
      sof = (i == 0);
      eof = (i + 2 == n);
      if (i + 1 < n)
         return {2'b00, eof, sof, w0, w1};
      else
         return {2'b10, 1'b1, sof, w0, 16'h0000};
   endfunction

   task automatic gpmc_write(gpmc_word_t w);
      em_drive  = 1'b1;
      em_d_drv  = w;
      em_ncs4_n = 1'b0;
      em_nwe    = 1'b0;
      repeat (4) @(negedge fifo_clk);
      em_nwe = 1'b1;
      repeat (4) @(negedge fifo_clk);
      em_ncs4_n = 1'b1;
      repeat (4) @(negedge fifo_clk);
   endtask

   task automatic gpmc_read(gpmc_word_t exp);
      em_drive  = 1'b0;
      em_ncs4_n = 1'b0;
      em_noe    = 1'b0;
      repeat (4) @(negedge fifo_clk);
      check_word("em_d_io", em_d, exp);
      em_noe = 1'b1;
      repeat (4) @(negedge fifo_clk);
      em_ncs4_n = 1'b1;
      repeat (4) @(negedge fifo_clk);
   endtask

   task automatic stream_rx(int n, gpmc_word_t base);
      int i;
      for (i = 0; i < n; i += 2) begin
         rx_data    = make_line(n, i, base);
         rx_src_rdy = 1'b1;
         @(posedge fifo_clk);
         while (!rx_dst_rdy)
            @(posedge fifo_clk);
         rx_lines_sent++;
         @(negedge fifo_clk);
      end
      rx_src_rdy = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Row runners
   ////////////////////////////////////////////////////////////

   task automatic run_tx(int n, gpmc_word_t base, bp_mode_t mode);
      int acc;
      int i;
      acc = (mode == BP_HOLD && n > TX_CAP) ? TX_CAP : n;
      exp_lines.delete();
      got_lines.delete();
      for (i = 0; i < acc; i += 2)
         exp_lines.push_back(make_line(n, i, base));
      tx_frame_len = frame_len_t'(n);
      tx_hold      = (mode == BP_HOLD);
      rand_bp      = (mode == BP_RAND);
      @(negedge fifo_clk);
      for (i = 0; i < n; i++)
         gpmc_write(gpmc_word_t'(base + i));
      if (mode == BP_HOLD) begin
         // Packer keeps the first two words, the rest wait in the FIFO
         check_flag("tx_have_space_o", tx_have_space, (FIFO_DEPTH - (acc - 2)) >= n);
         check_flag("bus_error_o", bus_error, n > TX_CAP);
         if (n > TX_CAP) begin
            bus_reset = 1'b1;
            @(negedge fifo_clk);
            bus_reset = 1'b0;
            @(negedge fifo_clk);
            check_flag("bus_error_o", bus_error, 1'b0);
         end
         tx_hold = 1'b0;
      end
      while (got_lines.size() < exp_lines.size())
         @(negedge fifo_clk);
      repeat (8) @(negedge fifo_clk);
      rand_bp = 1'b0;
      if (got_lines.size() != exp_lines.size())
         abort_run($sformatf("TX stream gave %0d lines where %0d were due",
                             got_lines.size(), exp_lines.size()));
      for (i = 0; i < exp_lines.size(); i++)
         check_line("tx_data_o", got_lines[i], exp_lines[i]);
      check_flag("tx_have_space_o", tx_have_space, n <= FIFO_DEPTH);
      check_flag("bus_error_o", bus_error, 1'b0);
   endtask

   task automatic run_rx(int n, gpmc_word_t base, bit ovf);
      int lines;
      int i;
      lines         = (n + 1) / 2;
      rx_lines_sent = 0;
      fork
         stream_rx(n, base);
      join_none
      if (ovf) begin
         // Buffer fills long before the eof line
         while (rx_lines_sent < RX_CAP / 2)
            @(negedge fifo_clk);
         repeat (20) @(negedge fifo_clk);
         if (rx_lines_sent != RX_CAP / 2)
            abort_run("RX stream kept taking lines while the buffer was full");
         check_flag("rx_dst_rdy_o", rx_dst_rdy, 1'b0);
         check_flag("rx_have_data_o", rx_have_data, 1'b0);
      end else begin
         while (!rx_have_data)
            @(negedge fifo_clk);
         check_len("rx_frame_len_o", rx_frame_len, frame_len_t'(n));
      end
      for (i = 0; i < n; i++)
         gpmc_read(gpmc_word_t'(base + i));
      while (rx_lines_sent < lines)
         @(negedge fifo_clk);
      repeat (4) @(negedge fifo_clk);
      check_flag("rx_have_data_o", rx_have_data, 1'b0);
      check_flag("rx_dst_rdy_o", rx_dst_rdy, 1'b1);
      check_flag("bus_error_o", bus_error, 1'b0);
   endtask

   // 40 cycles per table word plus margin
   initial begin
      int total;
      total = 0;
      foreach (rows[r])
         total += rows[r].len;
      repeat (total * 40 + 1000) @(posedge fifo_clk);
      abort_run("Timeout: the run did not finish in the allowed time");
   end

   initial begin
      rst_n         = 1'b0;
      em_drive      = 1'b0;
      em_d_drv      = '0;
      em_ncs4_n     = 1'b1;
      em_nwe        = 1'b1;
      em_noe        = 1'b1;
      bus_reset     = 1'b0;
      rx_data       = '0;
      rx_src_rdy    = 1'b0;
      tx_frame_len  = 16'd8;
      tx_hold       = 1'b0;
      rand_bp       = 1'b0;
      rx_lines_sent = 0;
      repeat (5) @(negedge fifo_clk);
      rst_n = 1'b1;
      @(negedge fifo_clk);

      // Idle state right after reset
      check_flag("tx_src_rdy_o", tx_src_rdy, 1'b0);
      check_flag("bus_error_o", bus_error, 1'b0);
      check_flag("rx_have_data_o", rx_have_data, 1'b0);
      check_flag("rx_dst_rdy_o", rx_dst_rdy, 1'b1);
      check_flag("tx_have_space_o", tx_have_space, 1'b1);

      for (int r = 0; r < NUM_ROWS; r++) begin
         case (rows[r].kind)
            ROW_TX, ROW_TX_OVF: run_tx(rows[r].len, rows[r].base, rows[r].bp);
            ROW_RX:             run_rx(rows[r].len, rows[r].base, 1'b0);
            default:            run_rx(rows[r].len, rows[r].base, 1'b1);
         endcase
      end

      $display("Regression passed");
      $finish;
   end

endmodule

/* design/fifo18_to_fifo36.sv */
// TX packer joining two 18-bit entries into one 36-bit stream line
`timescale 1ns/1ps

module fifo18_to_fifo36 import gpmc_pkg::*; (
   input  logic        fifo_clk_i,
   input  logic        rst_n_i,
   input  fifo_entry_t data_i,
   input  logic        src_rdy_i,
   output logic        dst_rdy_o,
   output fifo_line_t  data_o,
   output logic        src_rdy_o,
   input  logic        dst_rdy_i
);

   pack_state_t state;
   fifo_entry_t first_q;
   logic        take;

   // Input stalls while a finished line is still waiting
   assign dst_rdy_o = ~src_rdy_o | dst_rdy_i;
   assign take      = src_rdy_i & dst_rdy_o;

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         state     <= PACK_EMPTY;
         src_rdy_o <= 1'b0;
      end else begin
         if (src_rdy_o && dst_rdy_i)
            src_rdy_o <= 1'b0;
         if (take) begin
            case (state)
               PACK_EMPTY: begin
                  // Lone eof entry closes an odd frame
                  if (data_i[17])
                     src_rdy_o <= 1'b1;
                  else
                     state <= PACK_HALF;
               end
               PACK_HALF: begin
                  src_rdy_o <= 1'b1;
                  state     <= PACK_EMPTY;
               end
               default: state <= PACK_EMPTY;
            endcase
         end
      end
   end

   always_ff @(posedge fifo_clk_i) begin
      if (take) begin
         if (state == PACK_EMPTY) begin
            first_q <= data_i;
            data_o  <= {2'b10, 1'b1, data_i[16], data_i[15:0], 16'h0000};
         end else begin
            data_o  <= {2'b00, data_i[17], first_q[16], first_q[15:0], data_i[15:0]};
         end
      end
   end

endmodule

/* design/fifo36_to_fifo18.sv */
// RX splitter breaking 36-bit stream lines into 18-bit entries
`timescale 1ns/1ps

module fifo36_to_fifo18 import gpmc_pkg::*; (
   input  logic        fifo_clk_i,
   input  logic        rst_n_i,
   input  fifo_line_t  data_i,
   input  logic        src_rdy_i,
   output logic        dst_rdy_o,
   output fifo_entry_t data_o,
   output logic        src_rdy_o,
   input  logic        dst_rdy_i
);

   split_state_t state;
   fifo_line_t   line_q;
   logic         full_q;
   logic         half;
   logic         last_pop;
   logic         load;

   assign half      = (line_q[35:34] == 2'b10);
   assign src_rdy_o = full_q;

   // Last entry of the held line leaves, a new line may load the same cycle
   assign last_pop  = full_q & dst_rdy_i & ((state == SPLIT_LOW) | half);
   assign dst_rdy_o = ~full_q | last_pop;
   assign load      = src_rdy_i & dst_rdy_o;

   always_comb begin
      if (state == SPLIT_HIGH)
         data_o = {line_q[33] & half, line_q[32], line_q[31:16]};
      else
         data_o = {line_q[33], 1'b0, line_q[15:0]};
   end

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
         state  <= SPLIT_HIGH;
      end else begin
         if (load)
            full_q <= 1'b1;
         else if (last_pop)
            full_q <= 1'b0;
         if (last_pop)
            state <= SPLIT_HIGH;
         else if (full_q && dst_rdy_i)
            state <= SPLIT_LOW;
      end
   end

   always_ff @(posedge fifo_clk_i) begin
      if (load)
         line_q <= data_i;
   end

endmodule

/* design/fifo_to_gpmc.sv */
// RX read port serving host reads from the RX FIFO head
`timescale 1ns/1ps

module fifo_to_gpmc import gpmc_pkg::*; (
   input  logic        fifo_clk_i,
   input  logic        rst_n_i,
   input  fifo_entry_t data_i,
   input  logic        src_rdy_i,
   output logic        dst_rdy_o,
   input  logic        em_ncs_n_i,
   input  logic        em_noe_i,
   output gpmc_word_t  em_d_o
);

   logic [2:0] ncs_s;
   logic [2:0] noe_s;

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         ncs_s <= '1;
         noe_s <= '1;
      end else begin
         ncs_s <= {ncs_s[1:0], em_ncs_n_i};
         noe_s <= {noe_s[1:0], em_noe_i};
      end
   end

   // Pop at the end of the read strobe
   assign dst_rdy_o = noe_s[1] & ~noe_s[2] & ~ncs_s[2];

   // Zero on the bus when nothing is buffered
   assign em_d_o = src_rdy_i ? data_i[15:0] : '0;

   // Host reads only words that are buffered
   a_no_empty_pop: assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      dst_rdy_o |-> src_rdy_i);

endmodule

/* design/fifo_watcher.sv */
// RX frame tracker with length queue and head-frame length report
`timescale 1ns/1ps
`include "gpmc_params.svh"

module fifo_watcher import gpmc_pkg::*; (
   input  logic       fifo_clk_i,
   input  logic       rst_n_i,
   input  logic       src_rdy1_i,
   input  logic       dst_rdy1_i,
   input  logic       eof1_i,
   input  logic       src_rdy2_i,
   input  logic       dst_rdy2_i,
   input  logic       eof2_i,
   output logic       have_packet_o,
   output frame_len_t length_o,
   output logic       bus_error_o
);

   localparam int QAW    = `GPMC_LENQ_AW;
   localparam int QDEPTH = 1 << QAW;

   typedef logic [QAW:0] qptr_t;

   frame_len_t lenq [QDEPTH];
   frame_len_t word_cnt;
   qptr_t      wp;
   qptr_t      rp;
   logic       in_xfer;
   logic       in_eof;
   logic       out_eof;
   logic       q_full;

   assign in_xfer = src_rdy1_i & dst_rdy1_i;
   assign in_eof  = in_xfer & eof1_i;
   assign out_eof = src_rdy2_i & dst_rdy2_i & eof2_i;
   assign q_full  = (wp[QAW] != rp[QAW]) && (wp[QAW-1:0] == rp[QAW-1:0]);

   assign have_packet_o = (wp != rp);
   assign length_o      = lenq[rp[QAW-1:0]];

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         word_cnt    <= '0;
         wp          <= '0;
         rp          <= '0;
         bus_error_o <= 1'b0;
      end else begin
         if (in_xfer)
            word_cnt <= eof1_i ? '0 : word_cnt + 16'd1;
         if (in_eof) begin
            if (q_full)
               bus_error_o <= 1'b1;
            else
               wp <= wp + qptr_t'(1);
         end
         // Frame fully read out by the host
         if (out_eof && have_packet_o)
            rp <= rp + qptr_t'(1);
      end
   end

   always_ff @(posedge fifo_clk_i) begin
      if (in_eof && !q_full)
         lenq[wp[QAW-1:0]] <= word_cnt + 16'd1;
   end

endmodule

/* design/frame_fifo.sv */
// Show-ahead synchronous FIFO of 18-bit entries with free-space count
`timescale 1ns/1ps
`include "gpmc_params.svh"

module frame_fifo import gpmc_pkg::*; #(
   parameter int ADDR_W = `GPMC_FIFO_AW
) (
   input  logic        fifo_clk_i,
   input  logic        rst_n_i,
   input  fifo_entry_t data_i,
   input  logic        src_rdy_i,
   output logic        dst_rdy_o,
   output fifo_entry_t data_o,
   output logic        src_rdy_o,
   input  logic        dst_rdy_i,
   output fifo_count_t space_o
);

   localparam int DEPTH = 1 << ADDR_W;

   typedef logic [ADDR_W:0] ptr_t;

   fifo_entry_t mem [DEPTH];
   fifo_entry_t head_q;
   ptr_t        wr_ptr;
   ptr_t        rd_ptr;
   ptr_t        wr_nxt;
   ptr_t        rd_nxt;
   logic        full;
   logic        push;
   logic        pop;

   assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   assign dst_rdy_o = ~full;
   assign push      = src_rdy_i & ~full;
   assign pop       = src_rdy_o & dst_rdy_i;
   assign wr_nxt    = wr_ptr + ptr_t'(push);
   assign rd_nxt    = rd_ptr + ptr_t'(pop);
   assign space_o   = fifo_count_t'(DEPTH) - fifo_count_t'(wr_ptr - rd_ptr);

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         src_rdy_o <= 1'b0;
      end else begin
         wr_ptr    <= wr_nxt;
         rd_ptr    <= rd_nxt;
         src_rdy_o <= (wr_nxt != rd_nxt);
      end
   end

   // Storage and head register, bypass when the head slot is being written
   always_ff @(posedge fifo_clk_i) begin
      if (push)
         mem[wr_ptr[ADDR_W-1:0]] <= data_i;
      if (push && (wr_ptr == rd_nxt))
         head_q <= data_i;
      else
         head_q <= mem[rd_nxt[ADDR_W-1:0]];
   end

   assign data_o = head_q;

   // Valid head always matches the stored entry at the read pointer
   a_head_matches: assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      src_rdy_o |-> (head_q == mem[rd_ptr[ADDR_W-1:0]]));

endmodule

/* design/gpmc_async.sv */
// Bridge top with TX and RX frame paths and the tri-state host data bus
`timescale 1ns/1ps

module gpmc_async import gpmc_pkg::*; (
   input  logic            fifo_clk_i,
   input  logic            rst_n_i,
   inout  wire gpmc_word_t em_d_io,
   input  logic            em_ncs4_n_i,
   input  logic            em_nwe_i,
   input  logic            em_noe_i,
   output logic            rx_have_data_o,
   output logic            tx_have_space_o,
   output logic            bus_error_o,
   input  logic            bus_reset_i,
   output fifo_line_t      tx_data_o,
   output logic            tx_src_rdy_o,
   input  logic            tx_dst_rdy_i,
   input  fifo_line_t      rx_data_i,
   input  logic            rx_src_rdy_i,
   output logic            rx_dst_rdy_o,
   input  frame_len_t      tx_frame_len_i,
   output frame_len_t      rx_frame_len_o
);

   fifo_entry_t tx18_data;
   fifo_entry_t tx18b_data;
   logic        tx18_src_rdy;
   logic        tx18_dst_rdy;
   logic        tx18b_src_rdy;
   logic        tx18b_dst_rdy;
   fifo_count_t tx_fifo_space;

   fifo_entry_t rx18_data;
   fifo_entry_t rx18b_data;
   logic        rx18_src_rdy;
   logic        rx18_dst_rdy;
   logic        rx18b_src_rdy;
   logic        rx18b_dst_rdy;

   gpmc_word_t  rx_word;
   logic        bus_error_tx;
   logic        bus_error_rx;

   // Drive the bus only during a chip-select-4 read
   assign em_d_io     = (!em_ncs4_n_i && !em_noe_i) ? rx_word : 'z;
   assign bus_error_o = bus_error_tx | bus_error_rx;

   ////////////////////////////////////////////////////////////
   // TX path, host writes out to the line stream
   ////////////////////////////////////////////////////////////

   gpmc_to_fifo gpmc_to_fifo_i (
      .fifo_clk_i   (fifo_clk_i),
      .rst_n_i      (rst_n_i),
      .bus_reset_i  (bus_reset_i),
      .em_ncs_n_i   (em_ncs4_n_i),
      .em_nwe_i     (em_nwe_i),
      .em_d_i       (em_d_io),
      .frame_len_i  (tx_frame_len_i),
      .fifo_space_i (tx_fifo_space),
      .data_o       (tx18_data),
      .src_rdy_o    (tx18_src_rdy),
      .dst_rdy_i    (tx18_dst_rdy),
      .fifo_ready_o (tx_have_space_o),
      .bus_error_o  (bus_error_tx)
   );

   frame_fifo tx_fifo (
      .fifo_clk_i (fifo_clk_i),
      .rst_n_i    (rst_n_i),
      .data_i     (tx18_data),
      .src_rdy_i  (tx18_src_rdy),
      .dst_rdy_o  (tx18_dst_rdy),
      .data_o     (tx18b_data),
      .src_rdy_o  (tx18b_src_rdy),
      .dst_rdy_i  (tx18b_dst_rdy),
      .space_o    (tx_fifo_space)
   );

   fifo18_to_fifo36 fifo18_to_fifo36_i (
      .fifo_clk_i (fifo_clk_i),
      .rst_n_i    (rst_n_i),
      .data_i     (tx18b_data),
      .src_rdy_i  (tx18b_src_rdy),
      .dst_rdy_o  (tx18b_dst_rdy),
      .data_o     (tx_data_o),
      .src_rdy_o  (tx_src_rdy_o),
      .dst_rdy_i  (tx_dst_rdy_i)
   );

   ////////////////////////////////////////////////////////////
   // RX path, line stream in to host reads
   ////////////////////////////////////////////////////////////

   fifo36_to_fifo18 fifo36_to_fifo18_i (
      .fifo_clk_i (fifo_clk_i),
      .rst_n_i    (rst_n_i),
      .data_i     (rx_data_i),
      .src_rdy_i  (rx_src_rdy_i),
      .dst_rdy_o  (rx_dst_rdy_o),
      .data_o     (rx18_data),
      .src_rdy_o  (rx18_src_rdy),
      .dst_rdy_i  (rx18_dst_rdy)
   );

   // Free space is only watched on the TX side
   frame_fifo rx_fifo (
      .fifo_clk_i (fifo_clk_i),
      .rst_n_i    (rst_n_i),
      .data_i     (rx18_data),
      .src_rdy_i  (rx18_src_rdy),
      .dst_rdy_o  (rx18_dst_rdy),
      .data_o     (rx18b_data),
      .src_rdy_o  (rx18b_src_rdy),
      .dst_rdy_i  (rx18b_dst_rdy),
      .space_o    ()
   );

   fifo_to_gpmc fifo_to_gpmc_i (
      .fifo_clk_i (fifo_clk_i),
      .rst_n_i    (rst_n_i),
      .data_i     (rx18b_data),
      .src_rdy_i  (rx18b_src_rdy),
      .dst_rdy_o  (rx18b_dst_rdy),
      .em_ncs_n_i (em_ncs4_n_i),
      .em_noe_i   (em_noe_i),
      .em_d_o     (rx_word)
   );

   // Watches both sides of the RX FIFO without blocking either
   fifo_watcher fifo_watcher_i (
      .fifo_clk_i    (fifo_clk_i),
      .rst_n_i       (rst_n_i),
      .src_rdy1_i    (rx18_src_rdy),
      .dst_rdy1_i    (rx18_dst_rdy),
      .eof1_i        (rx18_data[17]),
      .src_rdy2_i    (rx18b_src_rdy),
      .dst_rdy2_i    (rx18b_dst_rdy),
      .eof2_i        (rx18b_data[17]),
      .have_packet_o (rx_have_data_o),
      .length_o      (rx_frame_len_o),
      .bus_error_o   (bus_error_rx)
   );

endmodule

/* design/gpmc_params.svh */
// Depth macros for the frame FIFOs and the RX frame-length queue
`ifndef GPMC_PARAMS_SVH
`define GPMC_PARAMS_SVH

// Log2 of entries per frame FIFO, 6 gives 64 entries
`define GPMC_FIFO_AW 6

// Log2 of frames the RX watcher can track at once
`define GPMC_LENQ_AW 2

`endif

/* design/gpmc_pkg.sv */
// Bridge word, entry, line, length and count types plus FSM state enums
package gpmc_pkg;

`include "gpmc_params.svh"

   // One host bus word
   typedef logic [15:0] gpmc_word_t;

   // 18-bit FIFO entry: [17] eof, [16] sof, [15:0] word
   typedef logic [17:0] fifo_entry_t;

   // 36-bit stream line
   //   [35:34] occupancy, 2'b10 means only the upper word is valid
   //   [33] eof, [32] sof, [31:16] first word, [15:0] second word
   typedef logic [35:0] fifo_line_t;

   // Frame length in words
   typedef logic [15:0] frame_len_t;

   // Free entry count of one frame FIFO
   typedef logic [`GPMC_FIFO_AW:0] fifo_count_t;

   typedef enum logic {
      PACK_EMPTY,
      PACK_HALF
   } pack_state_t;

   typedef enum logic {
      SPLIT_HIGH,
      SPLIT_LOW
   } split_state_t;

endpackage

/* design/gpmc_to_fifo.sv */
// TX write capture with frame boundary marking and sticky overflow flag
`timescale 1ns/1ps

module gpmc_to_fifo import gpmc_pkg::*; (
   input  logic        fifo_clk_i,
   input  logic        rst_n_i,
   input  logic        bus_reset_i,
   input  logic        em_ncs_n_i,
   input  logic        em_nwe_i,
   input  gpmc_word_t  em_d_i,
   input  frame_len_t  frame_len_i,
   input  fifo_count_t fifo_space_i,
   output fifo_entry_t data_o,
   output logic        src_rdy_o,
   input  logic        dst_rdy_i,
   output logic        fifo_ready_o,
   output logic        bus_error_o
);

   logic [2:0] ncs_s;
   logic [2:0] nwe_s;
   gpmc_word_t d_s;
   gpmc_word_t word_q;
   frame_len_t word_cnt;
   logic       wr_edge;
   logic       last_word;

   // Strobe synchronizers, stage 2 only serves edge detection
   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         ncs_s <= '1;
         nwe_s <= '1;
      end else begin
         ncs_s <= {ncs_s[1:0], em_ncs_n_i};
         nwe_s <= {nwe_s[1:0], em_nwe_i};
      end
   end

   // Bus word sampled alongside stage 0, kept while the strobe was low
   always_ff @(posedge fifo_clk_i) begin
      d_s <= em_d_i;
      if (!nwe_s[0])
         word_q <= d_s;
   end

   // Rising write strobe, chip select taken from the low phase
   assign wr_edge   = nwe_s[1] & ~nwe_s[2] & ~ncs_s[2];
   assign last_word = (word_cnt + 16'd1 == frame_len_i);

   always_ff @(posedge fifo_clk_i) begin
      if (!rst_n_i) begin
         src_rdy_o   <= 1'b0;
         bus_error_o <= 1'b0;
         word_cnt    <= '0;
      end else begin
         src_rdy_o <= wr_edge & dst_rdy_i;
         if (bus_reset_i) begin
            bus_error_o <= 1'b0;
            word_cnt    <= '0;
         end else if (wr_edge) begin
            // Full FIFO drops the word but framing keeps counting
            if (!dst_rdy_i)
               bus_error_o <= 1'b1;
            word_cnt <= last_word ? '0 : word_cnt + 16'd1;
         end
      end
   end

   always_ff @(posedge fifo_clk_i) begin
      if (wr_edge)
         data_o <= {last_word, word_cnt == '0, word_q};
   end

   // Room for a whole frame
   assign fifo_ready_o = (frame_len_t'(fifo_space_i) >= frame_len_i);

   // FIFO takes each offered word at once, strobes are far apart
   a_single_offer: assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      src_rdy_o |-> dst_rdy_i);

endmodule

/* vlog.f */
+incdir+design
design/gpmc_pkg.sv
design/gpmc_to_fifo.sv
design/frame_fifo.sv
design/fifo18_to_fifo36.sv
design/fifo36_to_fifo18.sv
design/fifo_watcher.sv
design/fifo_to_gpmc.sv
design/gpmc_async.sv
bench/gpmc_async_tb.sv
